//--- Makefile
# Verilator flow for the ROM loader testbench
# A run passes only if the log holds the pass line

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module rom_loader_tb \
		-f rom_loader_top.f --Mdir obj_dir -o rom_loader_sim

run: compile
	./obj_dir/rom_loader_sim | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- ines_header_decode.sv
/* Purely combinational, reads the header register as captured so far.
   Trainer images are rejected, iNES 2.0 extended fields are not decoded */
`timescale 1ns/1ps

module ines_header_decode (
  input  logic [8*nes_loader_pkg::HEADER_BYTES-1:0] header,
  output logic [31:0]                               mapper_flags,
  output logic                                      header_ok
);
  import nes_loader_pkg::*;

  logic [7:0] hb [HEADER_BYTES];  // Header split into bytes
  logic       is_nes20;
  logic       is_dirty;
  logic       chr_ram;
  logic [7:0] mapper;
  logic [2:0] prg_size;
  logic [2:0] chr_size;

  // Log2 style size code, saturates at 7 above 64 pages
  function automatic logic [2:0] size_code(input logic [7:0] pages);
    if (pages <= 8'd1) return 3'd0;
    else if (pages <= 8'd2) return 3'd1;
    else if (pages <= 8'd4) return 3'd2;
    else if (pages <= 8'd8) return 3'd3;
    else if (pages <= 8'd16) return 3'd4;
    else if (pages <= 8'd32) return 3'd5;
    else if (pages <= 8'd64) return 3'd6;
    else return 3'd7;
  endfunction

  always_comb begin
    for (int i = 0; i < HEADER_BYTES; i++)
      hb[i] = header[8*i +: 8];  // Byte 0 in the low bits
  end

  // Signature plus no trainer (byte 6 bit 2)
  assign header_ok = (hb[0] == INES_MAGIC0) && (hb[1] == INES_MAGIC1) &&
                     (hb[2] == INES_MAGIC2) && (hb[3] == INES_MAGIC3) &&
                     !hb[6][2];

  assign is_nes20 = (hb[7][3:2] == 2'b10);

  // Old dumps with junk in bytes 8..15 carry garbage in byte 7 too
  assign is_dirty = !is_nes20 && (|header[8*HEADER_BYTES-1:64]);

  assign mapper = {is_dirty ? 4'h0 : hb[7][7:4], hb[6][7:4]};
  assign chr_ram = (hb[5] == 8'd0);  // No CHR ROM pages
  assign prg_size = size_code(hb[4]);
  assign chr_size = size_code(hb[5]);

  assign mapper_flags = {
    15'd0,
    hb[6][3],  // Four-screen
    chr_ram,
    hb[6][0],  // Mirroring
    chr_size,
    prg_size,
    mapper
  };

endmodule

//--- ines_loader.sv
/* Bytes must arrive at least 8 cycles apart, there is no back-pressure on the
   write request. Loader idles and clears whenever downloading is low */
`timescale 1ns/1ps

module ines_loader (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [7:0]                        rx_byte,
  input  logic                              rx_strobe,
  input  logic                              downloading,
  output logic [nes_loader_pkg::ADDR_W-1:0] req_addr,
  output logic [7:0]                        req_data,
  output logic                              req_write,
  output logic [31:0]                       mapper_flags,
  output logic                              load_done,
  output logic                              load_error
);
  import nes_loader_pkg::*;

  logic [1:0]                      state;
  logic [$clog2(HEADER_BYTES)-1:0] hdr_idx;  // Next header byte slot
  logic [8*HEADER_BYTES-1:0]       header;
  logic [ADDR_W-1:0]               addr;
  logic [ADDR_W-1:0]               bytes_left;  // Remaining in current phase
  logic [7:0]                      prg_pages;
  logic [7:0]                      chr_pages;
  logic                            header_ok;
  logic                            in_data;

  ines_header_decode u_decode (
    .header      (header),
    .mapper_flags(mapper_flags),
    .header_ok   (header_ok)
  );

  assign prg_pages = header[8*4 +: 8];
  assign chr_pages = header[8*5 +: 8];
  assign in_data = (state == LD_PRG) || (state == LD_CHR);

  // Data bytes pass straight through with a same-cycle request
  assign req_write = rx_strobe && in_data && (bytes_left != '0);
  assign req_addr = addr;
  assign req_data = rx_byte;
  assign load_error = (state == LD_ERROR);

  // Header capture, payload only
  always_ff @(posedge clk) begin
    if (downloading && rx_strobe && state == LD_HEADER)
      header[8*hdr_idx +: 8] <= rx_byte;
  end

  always_ff @(posedge clk) begin
    if (reset || !downloading) begin
      state     <= LD_HEADER;
      hdr_idx   <= '0;
      addr      <= '0;  // PRG starts at 0
      load_done <= 1'b0;
    end else begin
      case (state)
        LD_HEADER: begin
          if (rx_strobe) begin
            hdr_idx <= hdr_idx + 1'b1;
            if (hdr_idx == HEADER_BYTES - 1) begin
              // Check only needs bytes 0..6, all captured by now
              state      <= header_ok ? LD_PRG : LD_ERROR;
              bytes_left <= ADDR_W'(prg_pages) << PRG_PAGE_SHIFT;
            end
          end
        end
        LD_PRG, LD_CHR: begin
          if (bytes_left != '0) begin
            if (rx_strobe) begin
              bytes_left <= bytes_left - 1'b1;
              addr       <= addr + 1'b1;  // Step after the write
            end
          end else if (state == LD_PRG) begin
            state      <= LD_CHR;
            addr       <= CHR_BASE_ADDR;
            bytes_left <= ADDR_W'(chr_pages) << CHR_PAGE_SHIFT;  // 0 for CHR RAM
          end else begin
            load_done <= 1'b1;  // Held until next idle
          end
        end
        default: ;  // ERROR waits for ss to rise
      endcase
    end
  end

endmodule

//--- mem_write_slot.sv
/* Holds a single pending write, so requests must be at least 4 cycles apart.
   mem_we follows the slot cycle by one clock */
`timescale 1ns/1ps

module mem_write_slot (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [nes_loader_pkg::ADDR_W-1:0] req_addr,
  input  logic [7:0]                        req_data,
  input  logic                              req_write,
  output logic [nes_loader_pkg::ADDR_W-1:0] mem_addr,
  output logic [7:0]                        mem_data,
  output logic                              mem_we
);
  import nes_loader_pkg::*;

  logic [1:0]        slot_cnt;  // Free running, shared with the console
  logic              pending;
  logic [ADDR_W-1:0] lat_addr;
  logic [7:0]        lat_data;
  logic              in_slot;

  assign in_slot = (slot_cnt == WRITE_SLOT);

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_cnt <= 2'd0;
      pending  <= 1'b0;
      mem_we   <= 1'b0;
    end else begin
      slot_cnt <= slot_cnt + 2'd1;
      mem_we   <= in_slot && (pending || req_write);  // Request in slot goes now
      if (in_slot)
        pending <= 1'b0;
      else if (req_write)
        pending <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (req_write) begin
      lat_addr <= req_addr;
      lat_data <= req_data;
    end
    if (in_slot) begin
      mem_addr <= req_write ? req_addr : lat_addr;  // Bypass the latch
      mem_data <= req_write ? req_data : lat_data;
    end
  end

endmodule

//--- nes_loader_pkg.sv
/* Constants for the iNES download path. Address space is 22 bits of bytes,
   CHR ROM sits in the top half, memory takes a write once every four cycles */
package nes_loader_pkg;

  // Memory byte address
  localparam int ADDR_W = 22;
  localparam logic [ADDR_W-1:0] CHR_BASE_ADDR = 22'h20_0000;  // Top half

  // Page sizes as shifts
  localparam int PRG_PAGE_SHIFT = 14;  // 16 KiB PRG pages
  localparam int CHR_PAGE_SHIFT = 13;  // 8 KiB CHR pages

  // iNES header
  localparam int HEADER_BYTES = 16;
  localparam logic [7:0] INES_MAGIC0 = 8'h4E;  // "N"
  localparam logic [7:0] INES_MAGIC1 = 8'h45;  // "E"
  localparam logic [7:0] INES_MAGIC2 = 8'h53;  // "S"
  localparam logic [7:0] INES_MAGIC3 = 8'h1A;  // MS-DOS EOF

  // Slot counter value where the memory accepts a loader write
  localparam logic [1:0] WRITE_SLOT = 2'd3;

  // Loader FSM encoding
  localparam logic [1:0] LD_HEADER = 2'd0;
  localparam logic [1:0] LD_PRG = 2'd1;
  localparam logic [1:0] LD_CHR = 2'd2;
  localparam logic [1:0] LD_ERROR = 2'd3;

endpackage

//--- rom_loader_tb.sv
/* Sends iNES images over the serial link and checks every memory write.
   About 41k image bytes at 48 clocks each, so a run is roughly 2M cycles */
`timescale 1ns/1ps

module rom_loader_tb;

  localparam int HALF_BIT = 3;  // sck half period in clocks
  localparam int MAX_CYCLES = 2_000_000;  // ~41k bytes x 48 cycles, with margin
  localparam int FLAG_WAIT = 200;  // Bound on waiting for a level
  localparam int WRITE_LAT = 8;  // Last strobe to mem_we is at most 4
  localparam int SYNC_LAT = 4;  // Sync, edge detect and strobe
  localparam logic [21:0] CHR_BASE = 22'h20_0000;  // Top half of 4 MiB
  localparam int PRG_BYTES = 16384;
  localparam int CHR_BYTES = 8192;

  logic        clk;
  logic        reset;
  logic        spi_sck;
  logic        spi_ss;
  logic        spi_sdi;
  logic [21:0] mem_addr;
  logic [7:0]  mem_data;
  logic        mem_we;
  logic [31:0] mapper_flags;
  logic        downloading;
  logic        load_done;
  logic        load_error;

  int          seed = 43;
  int          value_errors = 0;
  int          other_errors = 0;
  int          writes_seen = 0;
  int          cycles = 0;
  logic [21:0] exp_addr [$];  // Expected writes, in order
  logic [7:0]  exp_data [$];
  logic [21:0] want_addr;
  logic [7:0]  want_data;
  logic [7:0]  hdr [16];  // Header of the next image

  tb_clock_gen u_clk (.clk(clk), .reset(reset));

  rom_loader_top DUT (
    .clk         (clk),
    .reset       (reset),
    .spi_sck     (spi_sck),
    .spi_ss      (spi_ss),
    .spi_sdi     (spi_sdi),
    .mem_addr    (mem_addr),
    .mem_data    (mem_data),
    .mem_we      (mem_we),
    .mapper_flags(mapper_flags),
    .downloading (downloading),
    .load_done   (load_done),
    .load_error  (load_error)
  );

  task automatic tick();
    @(posedge clk);
    #1;  // Drive just after the edge
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      value_errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      other_errors++;
      $display("%0t %s", $time, what);
    end
  endtask

  // MSB first, sdi changes while sck is low
  task automatic send_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      spi_sdi = b[i];
      repeat (HALF_BIT) tick();
      spi_sck = 1'b1;
      repeat (HALF_BIT) tick();
      spi_sck = 1'b0;
    end
  endtask

  // Clean iNES 1.0 header
  task automatic set_header(input logic [7:0] prg, input logic [7:0] chr,
                            input logic [7:0] f6, input logic [7:0] f7);
    for (int i = 0; i < 16; i++)
      hdr[i] = 8'h00;
    hdr[0] = 8'h4E;  // N
    hdr[1] = 8'h45;  // E
    hdr[2] = 8'h53;  // S
    hdr[3] = 8'h1A;
    hdr[4] = prg;
    hdr[5] = chr;
    hdr[6] = f6;
    hdr[7] = f7;
  endtask

  task automatic send_header();
    for (int i = 0; i < 16; i++)
      send_byte(hdr[i]);
  endtask

  // Random bytes, each one queued as an expected write
  task automatic send_payload(input int count, input logic [21:0] base);
    logic [7:0] d;
    for (int i = 0; i < count; i++) begin
      d = 8'($random(seed));
      exp_addr.push_back(base + 22'(i));
      exp_data.push_back(d);
      send_byte(d);
    end
  endtask

  // Random bytes the DUT must drop, then time for a stray write to show
  task automatic send_ignored_bytes(input int count);
    for (int i = 0; i < count; i++)
      send_byte(8'($random(seed)));
    repeat (WRITE_LAT) tick();
  endtask

  // Waits for a level: 0 load_done high, 1 load_error high, 2 downloading low
  task automatic wait_flag(input int which, input string what);
    int   n;
    logic hit;
    n = 0;
    hit = 1'b0;
    while (!hit && n < FLAG_WAIT) begin
      @(negedge clk);
      case (which)
        0: hit = load_done;
        1: hit = load_error;
        default: hit = !downloading;
      endcase
      n++;
    end
    check_true(hit, {what, " did not happen in time"});
  endtask

  task automatic wait_writes_drained();
    int n;
    n = 0;
    while (exp_addr.size() != 0 && n < WRITE_LAT) begin
      @(negedge clk);
      n++;
    end
    check_true(exp_addr.size() == 0, "expected memory writes never appeared");
  endtask

  task automatic start_image();
    tick();
    spi_ss = 1'b0;
    repeat (HALF_BIT) tick();
  endtask

  task automatic end_image();
    tick();
    spi_ss = 1'b1;
    wait_flag(2, "downloading fall");
    repeat (4) tick();
  endtask

  // Write checker, sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && mem_we) begin
      writes_seen++;
      check_true(exp_addr.size() != 0,
                 $sformatf("unexpected memory write to address %h", mem_addr));
      if (exp_addr.size() != 0) begin
        want_addr = exp_addr.pop_front();
        want_data = exp_data.pop_front();
        check_value("mem_addr", want_addr, mem_addr);
        check_value("mem_data", want_data, mem_data);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, value errors %0d, other errors %0d",
               cycles, value_errors, other_errors + 1);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    spi_sck = 1'b0;
    spi_ss  = 1'b1;  // Idle deselected
    spi_sdi = 1'b0;
    wait (reset === 1'b0);
    tick();
    check_value("mem_we", 0, mem_we);
    check_value("load_done", 0, load_done);
    check_value("load_error", 0, load_error);
    check_value("downloading", 0, downloading);

    // Mapper 4, vertical mirroring, 1 PRG + 1 CHR page
    set_header(8'd1, 8'd1, 8'h41, 8'h00);
    start_image();
    send_header();
    send_payload(PRG_BYTES, 22'd0);
    send_payload(CHR_BYTES, CHR_BASE);
    wait_flag(0, "load_done rise");
    wait_writes_drained();
    check_value("mapper_flags", 32'h0000_4004, mapper_flags);  // Mirror bit 14, mapper 4
    end_image();

    // Abort after 100 PRG bytes
    start_image();
    send_header();
    send_payload(100, 22'd0);
    wait_writes_drained();
    end_image();
    check_value("load_done", 0, load_done);
    check_value("load_error", 0, load_error);

    // CHR RAM image, restarts from address 0
    set_header(8'd1, 8'd0, 8'h00, 8'h00);
    start_image();
    send_header();
    send_payload(PRG_BYTES, 22'd0);
    wait_flag(0, "load_done rise");
    wait_writes_drained();
    check_value("mapper_flags", 32'h0000_8000, mapper_flags);  // CHR RAM bit 15
    end_image();

    // Bad signature
    set_header(8'd1, 8'd1, 8'h00, 8'h00);
    hdr[3] = 8'h1B;
    start_image();
    send_header();
    wait_flag(1, "load_error rise");
    check_value("load_done", 0, load_done);
    send_ignored_bytes(4);  // Must not reach memory
    end_image();

    // Trainer present
    set_header(8'd1, 8'd1, 8'h04, 8'h00);
    start_image();
    send_header();
    wait_flag(1, "load_error rise");
    send_ignored_bytes(4);
    end_image();

    // Dirty 1.0 header, byte 7 nibble must be ignored
    set_header(8'd1, 8'd1, 8'h10, 8'h50);
    hdr[12] = 8'h7F;
    start_image();
    send_header();
    repeat (SYNC_LAT) tick();
    check_value("mapper_number", 32'h01, mapper_flags[7:0]);
    check_value("load_error", 0, load_error);
    end_image();

    $display("Value errors: %0d, other errors: %0d, writes checked: %0d",
             value_errors, other_errors, writes_seen);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- rom_loader_top.f
nes_loader_pkg.sv
spi_byte_rx.sv
ines_header_decode.sv
ines_loader.sv
mem_write_slot.sv
rom_loader_top.sv
tb_clock_gen.sv
rom_loader_tb.sv

//--- rom_loader_top.sv
/* Download path only, no SDRAM arbitration. mem_we comes from 1 to 4 cycles
   after a byte, memory must accept it in the cycle it is high */
`timescale 1ns/1ps

module rom_loader_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              spi_sck,
  input  logic                              spi_ss,
  input  logic                              spi_sdi,
  output logic [nes_loader_pkg::ADDR_W-1:0] mem_addr,
  output logic [7:0]                        mem_data,
  output logic                              mem_we,
  output logic [31:0]                       mapper_flags,
  output logic                              downloading,
  output logic                              load_done,
  output logic                              load_error
);
  import nes_loader_pkg::*;

  logic [7:0]        rx_byte;  // Byte link
  logic              rx_strobe;
  logic [ADDR_W-1:0] req_addr;  // Write request
  logic [7:0]        req_data;
  logic              req_write;

  spi_byte_rx u_rx (
    .clk        (clk),
    .reset      (reset),
    .spi_sck    (spi_sck),
    .spi_ss     (spi_ss),
    .spi_sdi    (spi_sdi),
    .rx_byte    (rx_byte),
    .rx_strobe  (rx_strobe),
    .downloading(downloading)
  );

  ines_loader u_loader (
    .clk         (clk),
    .reset       (reset),
    .rx_byte     (rx_byte),
    .rx_strobe   (rx_strobe),
    .downloading (downloading),
    .req_addr    (req_addr),
    .req_data    (req_data),
    .req_write   (req_write),
    .mapper_flags(mapper_flags),
    .load_done   (load_done),
    .load_error  (load_error)
  );

  mem_write_slot u_slot (
    .clk      (clk),
    .reset    (reset),
    .req_addr (req_addr),
    .req_data (req_data),
    .req_write(req_write),
    .mem_addr (mem_addr),
    .mem_data (mem_data),
    .mem_we   (mem_we)
  );

endmodule

//--- spi_byte_rx.sv
/* Serial lines are asynchronous and oversampled, so each sck bit must last at
   least 4 clk cycles. Bits arrive MSB first while ss is low */
`timescale 1ns/1ps

module spi_byte_rx (
  input  logic       clk,
  input  logic       reset,
  input  logic       spi_sck,
  input  logic       spi_ss,
  input  logic       spi_sdi,
  output logic [7:0] rx_byte,
  output logic       rx_strobe,
  output logic       downloading
);

  logic [1:0] sck_sync;  // Two-flop synchronizers
  logic [1:0] ss_sync;
  logic [1:0] sdi_sync;
  logic       sck_prev;  // Last synchronized sck for edge detect
  logic       sck_rise;
  logic [2:0] bit_cnt;
  logic [7:0] shift_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      sck_sync <= 2'b00;
      ss_sync  <= 2'b11;  // Select idles high
      sdi_sync <= 2'b00;
      sck_prev <= 1'b0;
    end else begin
      sck_sync <= {sck_sync[0], spi_sck};
      ss_sync  <= {ss_sync[0], spi_ss};
      sdi_sync <= {sdi_sync[0], spi_sdi};
      sck_prev <= sck_sync[1];
    end
  end

  // sdi goes through the same depth as sck, so data lines up with the edge
  assign sck_rise = sck_sync[1] & ~sck_prev;

  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt   <= 3'd0;
      rx_strobe <= 1'b0;
    end else begin
      rx_strobe <= 1'b0;
      if (ss_sync[1]) begin
        bit_cnt <= 3'd0;  // Deselect drops a partial byte
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;  // Wraps after the 8th bit
        if (bit_cnt == 3'd7)
          rx_strobe <= 1'b1;  // Byte complete, strobe next cycle
      end
    end
  end

  // Shift register is payload only
  always_ff @(posedge clk) begin
    if (!ss_sync[1] && sck_rise)
      shift_reg <= {shift_reg[6:0], sdi_sync[1]};  // MSB first
  end

  // Byte stays stable until the next sck edge, at least 4 cycles later
  assign rx_byte = shift_reg;
  assign downloading = ~ss_sync[1];

endmodule

//--- tb_clock_gen.sv
/* 100 ns clock, reset held high for the first 3 rising edges */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;  // Released just after the third edge
  end

endmodule
